// File: rtl/snes_load_pkg.sv
// load sequencing definitions shared by the control FSM,
// the phase divider and the clear pacing
package snes_load_pkg;

  // cart load sequencer states
  typedef enum logic [1:0] {
    // after reset, no cart loaded yet
    ST_IDLE   = 2'd0,
    // cart download in progress
    ST_LOAD   = 2'd1,
    // countdown after download end
    ST_SETTLE = 2'd2,
    // masks valid, core free to run
    ST_RUN    = 2'd3
  } load_state_t;

  // cycles spent in ST_SETTLE before the mask strobe
  // gives header parsing time to finish on the last word
  localparam logic [2:0] SETTLE_CYCLES = 3'd6;

  // width of the free-running phase divider
  localparam int PHASE_BITS = 2;

  // divider value at which core reset gets updated
  // refresh fires at phase 0, so release lands two slots later
  localparam logic [PHASE_BITS-1:0] RELEASE_PHASE = 2'd2;

endpackage

// File: rtl/snes_mem_pkg.sv
// memory map definitions for ROM download, core ROM bus,
// mask generation and RAM clear patterns
package snes_mem_pkg;

  // core ROM address, 16 MB window
  localparam int ROM_ADDR_BITS = 24;
  // download address, one bit wider to hold the copier header
  localparam int DL_ADDR_BITS = 25;
  // SDRAM data word
  localparam int DATA_BITS = 16;
  // clear address, covers 128 KB work-RAM
  localparam int FILL_ADDR_BITS = 17;
  // ROM and RAM size codes from the cart header
  localparam int SIZE_BITS = 4;
  // address masks handed to the core
  localparam int MASK_BITS = 24;

  // copier header in front of some dumps
  localparam logic [DL_ADDR_BITS-1:0] HEADER_BYTES = 25'd512;
  // bytes for size code 0
  localparam logic [MASK_BITS-1:0] MASK_BASE = 24'd1024;

  // fill pattern select for the RAM clear
  typedef enum logic [1:0] {
    // 66h / 99h on addr[8] ^ addr[2]
    FILL_CHECKER = 2'd0,
    // ffh / 00h on addr[9] ^ addr[0]
    FILL_STRIPE  = 2'd1,
    FILL_55      = 2'd2,
    FILL_FF      = 2'd3
  } fill_pattern_t;

endpackage

// File: rtl/cart_load_ctrl.sv
`timescale 1ns/1ps

// sequences download, settle and run
// and combines everything that keeps the core in reset
module cart_load_ctrl (
  input  logic clk_sys,
  input  logic reset,
  input  logic cart_download,
  input  logic core_reset_req,
  input  logic fill_busy,
  output logic clear_start,
  output logic mask_load,
  output logic hold_reset
);

  snes_load_pkg::load_state_t state;
  logic prev_download;
  logic [$bits(snes_load_pkg::SETTLE_CYCLES)-1:0] settle_cnt;
  logic dl_rise;
  logic dl_fall;

  // edges of the download level
  assign dl_rise = cart_download & ~prev_download;
  assign dl_fall = ~cart_download & prev_download;

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      state         <= snes_load_pkg::ST_IDLE;
      prev_download <= 1'b0;
      settle_cnt    <= '0;
      clear_start   <= 1'b0;
      mask_load     <= 1'b0;
    end else begin
      prev_download <= cart_download;
      // one-cycle strobes by default
      clear_start   <= 1'b0;
      mask_load     <= 1'b0;

      if (dl_rise) begin
        // new cart, restart from load even mid-settle
        state       <= snes_load_pkg::ST_LOAD;
        clear_start <= 1'b1;
        settle_cnt  <= '0;
      end else begin
        case (state)
          snes_load_pkg::ST_LOAD: begin
            if (dl_fall) begin
              state      <= snes_load_pkg::ST_SETTLE;
              settle_cnt <= '0;
            end
          end
          snes_load_pkg::ST_SETTLE: begin
            settle_cnt <= settle_cnt + 1'b1;
            // strobe lands in the last settle cycle
            if (settle_cnt == snes_load_pkg::SETTLE_CYCLES - 3'd2) begin
              mask_load <= 1'b1;
            end
            if (settle_cnt == snes_load_pkg::SETTLE_CYCLES - 3'd1) begin
              state <= snes_load_pkg::ST_RUN;
            end
          end
          // idle and run just wait for the next download
          default: begin
            settle_cnt <= '0;
          end
        endcase
      end
    end
  end

  // core held while loading, settling, clearing
  // or when the outside asks for it
  assign hold_reset = (state == snes_load_pkg::ST_LOAD) |
                      (state == snes_load_pkg::ST_SETTLE) |
                      fill_busy | core_reset_req;

endmodule

// File: rtl/ram_clear_gen.sv
`timescale 1ns/1ps

// clears work-RAM and audio-RAM after a download starts
// runs at quarter rate so the PSRAM keeps up
module ram_clear_gen (
  input  logic                                    clk_sys,
  input  logic                                    reset,
  input  logic                                    clear_start,
  input  snes_mem_pkg::fill_pattern_t             wram_pattern,
  input  snes_mem_pkg::fill_pattern_t             aram_pattern,
  output logic                                    fill_busy,
  output logic                                    fill_we,
  output logic [snes_mem_pkg::FILL_ADDR_BITS-1:0] fill_addr,
  output logic [7:0]                              wram_fill_data,
  output logic [7:0]                              aram_fill_data
);

  logic [snes_load_pkg::PHASE_BITS-1:0] clear_div;

  // fill byte for one pattern at one address
  function automatic logic [7:0] fill_byte(
    input snes_mem_pkg::fill_pattern_t       pat,
    input [snes_mem_pkg::FILL_ADDR_BITS-1:0] addr
  );
    case (pat)
      snes_mem_pkg::FILL_CHECKER: fill_byte = (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
      snes_mem_pkg::FILL_STRIPE:  fill_byte = (addr[9] ^ addr[0]) ? 8'hff : 8'h00;
      snes_mem_pkg::FILL_55:      fill_byte = 8'h55;
      default:                    fill_byte = 8'hff;
    endcase
  endfunction

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      clear_div <= '0;
      fill_busy <= 1'b0;
      fill_addr <= '0;
    end else begin
      clear_div <= clear_div + 1'b1;
      if (clear_start) begin
        // restart pacing so address 0 gets a full slot
        clear_div <= '0;
        fill_busy <= 1'b1;
        fill_addr <= '0;
      end else if (fill_busy) begin
        if (&fill_addr) begin
          // last location written, back to idle
          fill_busy <= 1'b0;
          fill_addr <= '0;
        end else if (&clear_div) begin
          fill_addr <= fill_addr + 1'b1;
        end
      end else begin
        // counter parked at zero while idle
        fill_addr <= '0;
      end
    end
  end

  // every busy cycle is a write
  assign fill_we = fill_busy;

  // separate pattern per RAM, same address
  assign wram_fill_data = fill_byte(wram_pattern, fill_addr);
  assign aram_fill_data = fill_byte(aram_pattern, fill_addr);

endmodule

// File: rtl/cart_mask_regs.sv
`timescale 1ns/1ps

// address masks and save-RAM size for the core
// latched once the settle countdown is over
module cart_mask_regs (
  input  logic                               clk_sys,
  input  logic                               reset,
  input  logic                               mask_load,
  input  logic [snes_mem_pkg::SIZE_BITS-1:0] rom_size,
  input  logic [snes_mem_pkg::SIZE_BITS-1:0] ram_size,
  output logic [snes_mem_pkg::MASK_BITS-1:0] rom_mask,
  output logic [snes_mem_pkg::MASK_BITS-1:0] ram_mask,
  output logic [snes_mem_pkg::SIZE_BITS-1:0] sram_size
);

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      rom_mask  <= '0;
      ram_mask  <= '0;
      sram_size <= '0;
    end else if (mask_load) begin
      // 1 KB << code, minus one gives the mask
      rom_mask <= (snes_mem_pkg::MASK_BASE << rom_size) - 1'b1;
      // code 0 means no cart RAM at all
      if (ram_size != '0) begin
        ram_mask <= (snes_mem_pkg::MASK_BASE << ram_size) - 1'b1;
      end else begin
        ram_mask <= '0;
      end
      sram_size <= ram_size;
    end
  end

endmodule

// File: rtl/core_phase_gen.sv
`timescale 1ns/1ps

// free-running phase divider
// paces the SDRAM refresh pulse and the core reset release
module core_phase_gen (
  input  logic clk_sys,
  input  logic reset,
  input  logic hold_reset,
  output logic refresh,
  output logic core_reset_n
);

  logic [snes_load_pkg::PHASE_BITS-1:0] phase_div;

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      phase_div    <= '0;
      refresh      <= 1'b0;
      core_reset_n <= 1'b0;
    end else begin
      phase_div <= phase_div + 1'b1;
      // one refresh slot per divider turn
      refresh   <= (phase_div == '0);
      // reset only moves on its own phase
      // keeps release aligned with the bus slots
      if (phase_div == snes_load_pkg::RELEASE_PHASE) begin
        core_reset_n <= ~hold_reset;
      end
    end
  end

endmodule

// File: rtl/rom_bus_mux.sv
`timescale 1ns/1ps

// steers the SDRAM request between the cart download
// and the core ROM bus
module rom_bus_mux (
  input  logic                                  cart_download,
  input  logic                                  has_header,
  input  logic [snes_mem_pkg::DL_ADDR_BITS-1:0] dl_addr,
  input  logic [snes_mem_pkg::DATA_BITS-1:0]    dl_data,
  input  logic                                  dl_wr,
  input  logic [snes_mem_pkg::ROM_ADDR_BITS-1:0] rom_addr,
  input  logic [snes_mem_pkg::DATA_BITS-1:0]    rom_d,
  input  logic                                  rom_oe_n,
  input  logic                                  rom_we_n,
  input  logic                                  rom_word,
  input  logic                                  core_reset_n,
  input  logic                                  refresh,
  output logic [snes_mem_pkg::DL_ADDR_BITS-1:0] sdram_addr,
  output logic [snes_mem_pkg::DATA_BITS-1:0]    sdram_din,
  output logic                                  sdram_rd,
  output logic                                  sdram_wr,
  output logic                                  sdram_word
);

  logic [snes_mem_pkg::DL_ADDR_BITS-1:0] dl_addr_strip;

  // drop the 512 byte copier header so ROM starts at 0
  assign dl_addr_strip = has_header ? dl_addr - snes_mem_pkg::HEADER_BYTES : dl_addr;

  always_comb begin
    if (cart_download) begin
      // download always writes full words, never reads
      sdram_addr = dl_addr_strip;
      sdram_din  = dl_data;
      sdram_wr   = dl_wr;
      sdram_word = 1'b1;
      sdram_rd   = 1'b0;
    end else begin
      sdram_addr = snes_mem_pkg::DL_ADDR_BITS'(rom_addr);
      sdram_din  = rom_d;
      sdram_wr   = ~rom_we_n;
      sdram_word = rom_word;
      // core in reset, idle slots used for refresh reads
      sdram_rd   = core_reset_n ? ~rom_oe_n : refresh;
    end
  end

endmodule

// File: rtl/snes_load_top.sv
`timescale 1ns/1ps

// cart load and memory preparation around the console core
module snes_load_top (
  input  logic                                   clk_sys,
  input  logic                                   reset,
  input  logic                                   cart_download,
  input  logic                                   core_reset_req,
  // download side
  input  logic                                   has_header,
  input  logic [snes_mem_pkg::DL_ADDR_BITS-1:0]  dl_addr,
  input  logic [snes_mem_pkg::DATA_BITS-1:0]     dl_data,
  input  logic                                   dl_wr,
  // core ROM bus
  input  logic [snes_mem_pkg::ROM_ADDR_BITS-1:0] rom_addr,
  input  logic [snes_mem_pkg::DATA_BITS-1:0]     rom_d,
  input  logic                                   rom_oe_n,
  input  logic                                   rom_we_n,
  input  logic                                   rom_word,
  // header info and clear options
  input  logic [snes_mem_pkg::SIZE_BITS-1:0]     rom_size,
  input  logic [snes_mem_pkg::SIZE_BITS-1:0]     ram_size,
  input  snes_mem_pkg::fill_pattern_t            wram_pattern,
  input  snes_mem_pkg::fill_pattern_t            aram_pattern,
  output logic                                   core_reset_n,
  output logic                                   refresh,
  // RAM clear toward PSRAM
  output logic                                   fill_busy,
  output logic                                   fill_we,
  output logic [snes_mem_pkg::FILL_ADDR_BITS-1:0] fill_addr,
  output logic [7:0]                             wram_fill_data,
  output logic [7:0]                             aram_fill_data,
  // masks for the core
  output logic [snes_mem_pkg::MASK_BITS-1:0]     rom_mask,
  output logic [snes_mem_pkg::MASK_BITS-1:0]     ram_mask,
  output logic [snes_mem_pkg::SIZE_BITS-1:0]     sram_size,
  // SDRAM request
  output logic [snes_mem_pkg::DL_ADDR_BITS-1:0]  sdram_addr,
  output logic [snes_mem_pkg::DATA_BITS-1:0]     sdram_din,
  output logic                                   sdram_rd,
  output logic                                   sdram_wr,
  output logic                                   sdram_word
);

  logic clear_start;
  logic mask_load;
  logic hold_reset;

  cart_load_ctrl cart_load_ctrl_inst (
    .clk_sys(clk_sys), .reset(reset), .cart_download(cart_download),
    .core_reset_req(core_reset_req), .fill_busy(fill_busy),
    .clear_start(clear_start), .mask_load(mask_load), .hold_reset(hold_reset)
  );

  ram_clear_gen ram_clear_gen_inst (
    .clk_sys(clk_sys), .reset(reset), .clear_start(clear_start),
    .wram_pattern(wram_pattern), .aram_pattern(aram_pattern),
    .fill_busy(fill_busy), .fill_we(fill_we), .fill_addr(fill_addr),
    .wram_fill_data(wram_fill_data), .aram_fill_data(aram_fill_data)
  );

  cart_mask_regs cart_mask_regs_inst (
    .clk_sys(clk_sys), .reset(reset), .mask_load(mask_load),
    .rom_size(rom_size), .ram_size(ram_size),
    .rom_mask(rom_mask), .ram_mask(ram_mask), .sram_size(sram_size)
  );

  core_phase_gen core_phase_gen_inst (
    .clk_sys(clk_sys), .reset(reset), .hold_reset(hold_reset),
    .refresh(refresh), .core_reset_n(core_reset_n)
  );

  rom_bus_mux rom_bus_mux_inst (
    .cart_download(cart_download), .has_header(has_header),
    .dl_addr(dl_addr), .dl_data(dl_data), .dl_wr(dl_wr),
    .rom_addr(rom_addr), .rom_d(rom_d), .rom_oe_n(rom_oe_n),
    .rom_we_n(rom_we_n), .rom_word(rom_word),
    .core_reset_n(core_reset_n), .refresh(refresh),
    .sdram_addr(sdram_addr), .sdram_din(sdram_din), .sdram_rd(sdram_rd),
    .sdram_wr(sdram_wr), .sdram_word(sdram_word)
  );

endmodule

// File: test/snes_load_checker.sv
`timescale 1ns/1ps

// bus steering and sequencing rules on the load top level
module snes_load_checker (
  input logic                                  clk_sys,
  input logic                                  reset,
  input logic                                  cart_download,
  input logic                                  has_header,
  input logic [snes_mem_pkg::DL_ADDR_BITS-1:0] dl_addr,
  input logic                                  core_reset_n,
  input logic                                  refresh,
  input logic [snes_mem_pkg::DL_ADDR_BITS-1:0] sdram_addr,
  input logic                                  sdram_rd,
  input logic                                  sdram_word,
  input logic                                  fill_busy,
  input logic                                  clear_start,
  input logic                                  mask_load,
  input snes_load_pkg::load_state_t            load_state
);

  // failed assertions so far
  int fail_count = 0;

  function automatic void count_failure(input string what);
    fail_count++;
    $error("assertion failed: %s", what);
  endfunction

  // refresh is a single-cycle pulse
  a_refresh_pulse: assert property (@(posedge clk_sys) disable iff (!reset)
    refresh |=> !refresh) else count_failure("refresh longer than one cycle");

  // download owns the bus, full-word writes, copier header stripped
  a_download_steer: assert property (@(posedge clk_sys) disable iff (!reset)
    cart_download |-> sdram_word && !sdram_rd &&
    sdram_addr == (has_header ? dl_addr - snes_mem_pkg::HEADER_BYTES : dl_addr))
    else count_failure("download steering");

  // idle slots become refresh reads while the core is held
  a_refresh_read: assert property (@(posedge clk_sys) disable iff (!reset)
    (!cart_download && !core_reset_n) |-> sdram_rd == refresh)
    else count_failure("refresh read steering");

  // clear comes up right after its start strobe
  a_clear_start: assert property (@(posedge clk_sys) disable iff (!reset)
    clear_start |=> fill_busy) else count_failure("clear did not start");

  // mask strobe only out of the settle countdown
  a_mask_settle: assert property (@(posedge clk_sys) disable iff (!reset)
    mask_load |-> load_state == snes_load_pkg::ST_SETTLE)
    else count_failure("mask load outside settle");

endmodule

// File: test/tb_snes_load.sv
`timescale 1ns/1ps

module tb_snes_load;

  // two full clears with settle time, doubled
  localparam int CLEAR_CYCLES = 4 << snes_mem_pkg::FILL_ADDR_BITS;
  localparam int WATCHDOG_CYCLES =
    4 * (CLEAR_CYCLES + int'(snes_load_pkg::SETTLE_CYCLES) + 200);

  logic                                   clk_sys;
  logic                                   reset;
  logic                                   cart_download;
  logic                                   core_reset_req;
  logic                                   has_header;
  logic [snes_mem_pkg::DL_ADDR_BITS-1:0]  dl_addr;
  logic [snes_mem_pkg::DATA_BITS-1:0]     dl_data;
  logic                                   dl_wr;
  logic [snes_mem_pkg::ROM_ADDR_BITS-1:0] rom_addr;
  logic [snes_mem_pkg::DATA_BITS-1:0]     rom_d;
  logic                                   rom_oe_n;
  logic                                   rom_we_n;
  logic                                   rom_word;
  logic [snes_mem_pkg::SIZE_BITS-1:0]     rom_size;
  logic [snes_mem_pkg::SIZE_BITS-1:0]     ram_size;
  snes_mem_pkg::fill_pattern_t            wram_pattern;
  snes_mem_pkg::fill_pattern_t            aram_pattern;
  logic                                   core_reset_n;
  logic                                   refresh;
  logic                                   fill_busy;
  logic                                   fill_we;
  logic [snes_mem_pkg::FILL_ADDR_BITS-1:0] fill_addr;
  logic [7:0]                             wram_fill_data;
  logic [7:0]                             aram_fill_data;
  logic [snes_mem_pkg::MASK_BITS-1:0]     rom_mask;
  logic [snes_mem_pkg::MASK_BITS-1:0]     ram_mask;
  logic [snes_mem_pkg::SIZE_BITS-1:0]     sram_size;
  logic [snes_mem_pkg::DL_ADDR_BITS-1:0]  sdram_addr;
  logic [snes_mem_pkg::DATA_BITS-1:0]     sdram_din;
  logic                                   sdram_rd;
  logic                                   sdram_wr;
  logic                                   sdram_word;

  integer seed;
  int errors;
  string test_name;
  logic [snes_mem_pkg::MASK_BITS-1:0] exp_rom_mask;
  logic [snes_mem_pkg::MASK_BITS-1:0] exp_ram_mask;
  logic [snes_mem_pkg::SIZE_BITS-1:0] exp_sram_size;
  // monitor history
  int warm;
  logic [3:0] refresh_hist;
  logic [3:0] hold_hist;
  logic [snes_mem_pkg::FILL_ADDR_BITS-1:0] exp_addr;
  int addr_age;
  logic prev_busy;
  logic prev_last;

  snes_load_top snes_load_top_inst (.*);

  bind snes_load_top snes_load_checker load_checker_inst (
    .*,
    .load_state(cart_load_ctrl_inst.state)
  );

  function automatic void check_value(input string what, input logic [31:0] expected,
                                      input logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endfunction

  // fill byte by pattern rule at one address
  function automatic logic [7:0] expected_fill(input snes_mem_pkg::fill_pattern_t sel,
                                               input logic [16:0] a);
    case (sel)
      snes_mem_pkg::FILL_CHECKER: return (a[8] != a[2]) ? 8'h66 : 8'h99;
      snes_mem_pkg::FILL_STRIPE:  return (a[9] != a[0]) ? 8'hff : 8'h00;
      snes_mem_pkg::FILL_55:      return 8'h55;
      default:                    return 8'hff;
    endcase
  endfunction

  // core reset has to come up within one divider turn
  task automatic wait_release();
    int n;
    n = 0;
    while (!core_reset_n && n < 4) begin
      @(negedge clk_sys);
      n++;
    end
    check_value("reset release", 1, core_reset_n);
  endtask

  // random core ROM requests while the core runs
  task automatic drive_core_bus(input int cycles);
    test_name = "core bus";
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk_sys);
      rom_addr <= 24'($random(seed));
      rom_d <= 16'($random(seed));
      rom_oe_n <= 1'($random(seed));
      rom_we_n <= 1'($random(seed));
      rom_word <= 1'($random(seed));
    end
    @(negedge clk_sys);
  endtask

  task automatic run_download(input logic hdr, input logic [3:0] ram_code);
    logic [3:0] rom_code;
    logic [24:0] a;
    logic [24:0] exp_a;
    logic [15:0] d;
    logic w;
    int n;
    test_name = hdr ? "download with header" : "download without header";
    // codes above 13 overflow the 24 bit mask
    rom_code = 4'($unsigned($random(seed)) % 14);
    @(posedge clk_sys);
    cart_download <= 1'b1;
    has_header <= hdr;
    rom_size <= rom_code;
    ram_size <= ram_code;
    // clear starts two edges after the download rises
    @(negedge clk_sys);
    check_value("busy before start", 0, fill_busy);
    @(negedge clk_sys);
    check_value("busy before start", 0, fill_busy);
    @(negedge clk_sys);
    check_value("busy at start", 1, fill_busy);
    check_value("addr at start", 0, fill_addr);
    for (int i = 0; i < 24; i++) begin
      a = 25'($random(seed));
      d = 16'($random(seed));
      w = 1'($random(seed));
      @(posedge clk_sys);
      dl_addr <= a;
      dl_data <= d;
      dl_wr <= w;
      @(negedge clk_sys);
      exp_a = hdr ? a - 25'd512 : a;
      check_value("sdram addr", exp_a, sdram_addr);
      check_value("sdram din", d, sdram_din);
      check_value("sdram wr", w, sdram_wr);
      check_value("sdram word", 1, sdram_word);
      check_value("sdram rd", 0, sdram_rd);
      // reset release lags the hold by up to one turn
      if (i >= 4) check_value("core reset", 0, core_reset_n);
    end
    @(posedge clk_sys);
    cart_download <= 1'b0;
    dl_wr <= 1'b0;
    // masks still old before the seventh edge after the fall
    repeat (6) @(posedge clk_sys);
    @(negedge clk_sys);
    check_value("rom mask early", exp_rom_mask, rom_mask);
    check_value("ram mask early", exp_ram_mask, ram_mask);
    exp_rom_mask = (24'd1 << (rom_code + 10)) - 24'd1;
    exp_ram_mask = (ram_code == 4'd0) ? 24'd0 : (24'd1 << (ram_code + 10)) - 24'd1;
    exp_sram_size = ram_code;
    @(negedge clk_sys);
    check_value("rom mask", exp_rom_mask, rom_mask);
    check_value("ram mask", exp_ram_mask, ram_mask);
    check_value("sram size", exp_sram_size, sram_size);
    // rotate patterns so every select shows up in the clear
    test_name = "ram clear";
    n = 0;
    while (fill_busy) begin
      @(posedge clk_sys);
      n++;
      rom_oe_n <= 1'($random(seed));
      if (n % 8192 == 0) begin
        wram_pattern <= snes_mem_pkg::fill_pattern_t'(2'(n >> 13));
        aram_pattern <= snes_mem_pkg::fill_pattern_t'(2'((n >> 13) + 1));
      end
      @(negedge clk_sys);
    end
    wait_release();
  endtask

  initial begin
    clk_sys = 1'b0;
    forever #4 clk_sys = ~clk_sys;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
    $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // per-cycle checks at mid cycle
  always @(negedge clk_sys) begin
    if (!reset) begin
      warm = 0;
      refresh_hist = '0;
      hold_hist = '0;
      prev_busy = 1'b0;
      prev_last = 1'b0;
    end else begin
      if (warm >= 4) check_value("refresh period", refresh_hist[3], refresh);
      if (refresh) check_value("refresh gap", 0, |refresh_hist[2:0]);
      // a full turn of hold leaves the core in reset
      if (&hold_hist) check_value("core held", 0, core_reset_n);
      if (!cart_download) check_value("rd steering", core_reset_n ? !rom_oe_n : refresh, sdram_rd);
      // core requests pass through when no download runs
      if (!cart_download) begin
        check_value("core addr", rom_addr, sdram_addr);
        check_value("core din", rom_d, sdram_din);
        check_value("core wr", !rom_we_n, sdram_wr);
        check_value("core word", rom_word, sdram_word);
      end
      if (fill_busy) begin
        if (!prev_busy) begin
          exp_addr = '0;
          addr_age = 1;
        end else if (addr_age == 4) begin
          exp_addr = exp_addr + 17'd1;
          addr_age = 1;
        end else begin
          addr_age++;
        end
        check_value("fill addr", exp_addr, fill_addr);
        check_value("wram fill", expected_fill(wram_pattern, exp_addr), wram_fill_data);
        check_value("aram fill", expected_fill(aram_pattern, exp_addr), aram_fill_data);
      end
      // busy drops right after the last address, never before
      if (prev_busy) check_value("fill end", !prev_last, fill_busy);
      check_value("fill we", fill_busy, fill_we);
      refresh_hist = {refresh_hist[2:0], refresh};
      hold_hist = {hold_hist[2:0], fill_busy | core_reset_req};
      prev_busy = fill_busy;
      prev_last = &fill_addr;
      warm++;
    end
  end

  initial begin
    seed = 32'h1778_3623;
    errors = 0;
    test_name = "reset";
    exp_rom_mask = '0;
    exp_ram_mask = '0;
    exp_sram_size = '0;
    reset = 1'b0;
    cart_download = 1'b0;
    core_reset_req = 1'b0;
    has_header = 1'b0;
    dl_addr = '0;
    dl_data = '0;
    dl_wr = 1'b0;
    rom_addr = 24'($random(seed));
    rom_d = 16'($random(seed));
    rom_oe_n = 1'b1;
    rom_we_n = 1'b1;
    rom_word = 1'b0;
    rom_size = '0;
    ram_size = '0;
    wram_pattern = snes_mem_pkg::FILL_CHECKER;
    aram_pattern = snes_mem_pkg::FILL_STRIPE;
    repeat (16) @(posedge clk_sys);
    reset <= 1'b1;
    @(negedge clk_sys);
    check_value("fill busy", 0, fill_busy);
    check_value("fill we", 0, fill_we);
    check_value("rom mask", 0, rom_mask);
    check_value("ram mask", 0, ram_mask);
    check_value("sram size", 0, sram_size);
    wait_release();
    drive_core_bus(16);
    run_download(1'b1, 4'd0);
    run_download(1'b0, 4'd1 + 4'($unsigned($random(seed)) % 7));
    drive_core_bus(16);
    // outside request holds the core on its own
    test_name = "reset request";
    @(posedge clk_sys);
    core_reset_req <= 1'b1;
    repeat (12) @(negedge clk_sys);
    check_value("core reset", 0, core_reset_n);
    @(posedge clk_sys);
    core_reset_req <= 1'b0;
    @(negedge clk_sys);
    wait_release();
    $display("errors: testbench %0d, assertions %0d", errors,
             snes_load_top_inst.load_checker_inst.fail_count);
    if (errors == 0 && snes_load_top_inst.load_checker_inst.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
rtl/snes_load_pkg.sv
rtl/snes_mem_pkg.sv
rtl/cart_load_ctrl.sv
rtl/ram_clear_gen.sv
rtl/cart_mask_regs.sv
rtl/core_phase_gen.sv
rtl/rom_bus_mux.sv
rtl/snes_load_top.sv
test/snes_load_checker.sv
test/tb_snes_load.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_snes_load -f project.f
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vtb_snes_load +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^ALL TESTS PASSED$"; then
  exit 0
fi
echo "pass message not found"
exit 1
